//--- logic/calc_num_pkg.sv
`default_nettype none

package calc_num_pkg;

    //////////////////////////////////////////////////////////////////////
    // decimal entry format
    //////////////////////////////////////////////////////////////////////

    // one BCD digit of the operand display
    typedef logic [3:0] digit_t;

    // largest value a single digit may hold
    localparam digit_t DIGIT_MAX = 4'd9;

    // edit position: 0 ones, 1 tens, 2 hundreds, 3 sign
    typedef logic [1:0] cursor_t;

    localparam cursor_t CURSOR_SIGN = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // binary values
    //////////////////////////////////////////////////////////////////////

    // stored operand, -999 .. 999
    typedef logic signed [10:0] operand_t;

    // arithmetic result, wide enough for -1998 .. 1998
    typedef logic signed [11:0] result_t;

endpackage

`default_nettype wire

//--- logic/calc_ctrl_pkg.sv
`default_nettype none

package calc_ctrl_pkg;

    // operations offered by the arithmetic unit
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_min,
        op_max
    } calc_op_e;

    // arithmetic sequencer
    typedef enum logic [1:0] {
        st_idle,
        st_read_a,
        st_read_b,
        st_calc
    } arith_state_e;

    // operand memory address
    typedef logic slot_t;

    localparam slot_t SLOT_A = 1'b0;
    localparam slot_t SLOT_B = 1'b1;

    // memory requesters, one bit each in request and grant vectors
    typedef logic [1:0] req_vec_t;

    localparam int REQ_WR = 0;
    localparam int REQ_RD = 1;

endpackage

`default_nettype wire

//--- logic/button_debouncer.sv
`default_nettype none

module button_debouncer #(
    parameter int TICK_DIVISOR = 1_000_000
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic btn_center,
    input  wire logic btn_up,
    input  wire logic btn_down,
    input  wire logic btn_left,
    input  wire logic btn_right,
    output logic      press_center,
    output logic      press_up,
    output logic      press_down,
    output logic      press_left,
    output logic      press_right
);

    localparam int CNT_W = (TICK_DIVISOR > 1) ? $clog2(TICK_DIVISOR) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;
    logic             tick_q;
    logic [4:0]       btn_vec;
    logic [4:0]       samp_new;
    logic [4:0]       samp_old;
    logic [4:0]       press_q;

    // sampling tick, one clk wide
    assign tick = (tick_cnt == CNT_W'(TICK_DIVISOR - 1));

    assign btn_vec = {btn_center, btn_up, btn_down, btn_left, btn_right};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick_q   <= 1'b0;
            samp_new <= '0;
            samp_old <= '0;
            press_q  <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            tick_q   <= tick;
            if (tick) begin
                samp_new <= btn_vec;
                samp_old <= samp_new;
            end
            // rising edge between two samples, pulse once
            press_q <= tick_q ? (samp_new & ~samp_old) : '0;
        end
    end

    assign press_center = press_q[4];
    assign press_up     = press_q[3];
    assign press_down   = press_q[2];
    assign press_left   = press_q[1];
    assign press_right  = press_q[0];

endmodule

`default_nettype wire

//--- logic/operand_entry.sv
`default_nettype none

module operand_entry import calc_num_pkg::*, calc_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     press_center,
    input  wire logic     press_up,
    input  wire logic     press_down,
    input  wire logic     press_left,
    input  wire logic     press_right,
    input  wire logic     wr_gnt,
    output digit_t        ones,
    output digit_t        tens,
    output digit_t        hundreds,
    output logic          sign,
    output cursor_t       cursor,
    output slot_t         slot,
    output logic          busy,
    output logic          wr_req,
    output slot_t         wr_slot,
    output operand_t      wr_data
);

    // binary copy of the three digits, 0 .. 999
    logic [9:0] magnitude;
    digit_t     cur_digit;
    logic [9:0] place;
    logic       at_sign;
    logic       step_up;
    logic       step_dn;
    logic       digit_we;
    digit_t     new_digit;
    logic [9:0] new_mag;
    operand_t   signed_value;

    //////////////////////////////////////////////////////////////////////
    // digit under the cursor
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cursor)
            2'd0: begin
                cur_digit = ones;
                place     = 10'd1;
            end
            2'd1: begin
                cur_digit = tens;
                place     = 10'd10;
            end
            2'd2: begin
                cur_digit = hundreds;
                place     = 10'd100;
            end
            default: begin
                cur_digit = '0;
                place     = '0;
            end
        endcase
    end

    assign at_sign = (cursor == CURSOR_SIGN);

    // saturate at 9 and at 0
    assign step_up  = press_up && !at_sign && (cur_digit < DIGIT_MAX);
    assign step_dn  = press_down && !at_sign && (cur_digit != '0);
    assign digit_we = step_up || step_dn;

    assign new_digit = step_up ? cur_digit + 4'd1 : cur_digit - 4'd1;
    assign new_mag   = step_up ? magnitude + place : magnitude - place;

    assign signed_value = sign ? -operand_t'(magnitude) : operand_t'(magnitude);

    //////////////////////////////////////////////////////////////////////
    // editing and commit
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ones      <= '0;
            tens      <= '0;
            hundreds  <= '0;
            magnitude <= '0;
            sign      <= 1'b0;
            cursor    <= '0;
            slot      <= SLOT_A;
            busy      <= 1'b0;
            wr_req    <= 1'b0;
        end else if (busy) begin
            // wait for the write to be taken, then move to the other slot
            if (wr_gnt) begin
                busy   <= 1'b0;
                wr_req <= 1'b0;
                slot   <= ~slot;
            end
        end else if (press_center) begin
            busy   <= 1'b1;
            wr_req <= 1'b1;
        end else if (press_left) begin
            cursor <= cursor + 2'd1;
        end else if (press_right) begin
            cursor <= cursor - 2'd1;
        end else if ((press_up || press_down) && at_sign) begin
            sign <= ~sign;
        end else if (digit_we) begin
            magnitude <= new_mag;
            case (cursor)
                2'd0: ones <= new_digit;
                2'd1: tens <= new_digit;
                default: hundreds <= new_digit;
            endcase
        end
    end

    // write payload, held stable while busy
    always_ff @(posedge clk) begin
        if (!busy && press_center) begin
            wr_slot <= slot;
            wr_data <= signed_value;
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_store_arbiter.sv
`default_nettype none

module operand_store_arbiter import calc_num_pkg::*, calc_ctrl_pkg::*; (
    input  wire logic     wr_req,
    input  wire slot_t    wr_slot,
    input  wire operand_t wr_data,
    input  wire logic     rd_req,
    input  wire slot_t    rd_slot,
    output logic          wr_gnt,
    output logic          rd_gnt,
    output logic          mem_we,
    output slot_t         mem_addr,
    output operand_t      mem_wdata,
    output logic          mem_re
);

    req_vec_t req;
    req_vec_t gnt;

    //////////////////////////////////////////////////////////////////////
    // fixed priority, writer first
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        req         = '0;
        req[REQ_WR] = wr_req;
        req[REQ_RD] = rd_req;

        gnt         = '0;
        gnt[REQ_WR] = req[REQ_WR];
        gnt[REQ_RD] = req[REQ_RD] && !req[REQ_WR];
    end

    assign wr_gnt = gnt[REQ_WR];
    assign rd_gnt = gnt[REQ_RD];

    // memory port follows the winner
    assign mem_we    = gnt[REQ_WR];
    assign mem_re    = gnt[REQ_RD];
    assign mem_addr  = gnt[REQ_WR] ? wr_slot : rd_slot;
    assign mem_wdata = wr_data;

endmodule

`default_nettype wire

//--- logic/operand_memory.sv
`default_nettype none

module operand_memory import calc_num_pkg::*, calc_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     mem_we,
    input  wire logic     mem_re,
    input  wire slot_t    mem_addr,
    input  wire operand_t mem_wdata,
    output operand_t      rd_data
);

    // slot A at 0, slot B at 1
    operand_t mem [0:1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end
            // read data shows up the cycle after the grant
            if (mem_re) begin
                rd_data <= mem[mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/arith_unit.sv
`default_nettype none

module arith_unit import calc_num_pkg::*, calc_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     go,
    input  wire calc_op_e op,
    input  wire logic     rd_gnt,
    input  wire operand_t rd_data,
    output logic          rd_req,
    output slot_t         rd_slot,
    output result_t       result,
    output logic          result_valid
);

    arith_state_e state;
    calc_op_e     op_q;
    operand_t     a_q;
    // rd_data holds the word granted last cycle
    logic         rd_gnt_q;
    result_t      a_ext;
    result_t      b_ext;
    result_t      calc_value;

    assign rd_req  = (state == st_read_a) || (state == st_read_b);
    assign rd_slot = (state == st_read_b) ? SLOT_B : SLOT_A;

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= st_idle;
            rd_gnt_q     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            rd_gnt_q     <= rd_gnt;
            result_valid <= 1'b0;
            case (state)
                st_idle:   if (go) state <= st_read_a;
                st_read_a: if (rd_gnt) state <= st_read_b;
                st_read_b: if (rd_gnt) state <= st_calc;
                // B was granted on the way in, so its word is on rd_data
                st_calc: begin
                    result_valid <= 1'b1;
                    state        <= st_idle;
                end
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && go) begin
            op_q <= op;
        end
        // first cycle of st_read_b carries slot A
        if (state == st_read_b && rd_gnt_q) begin
            a_q <= rd_data;
        end
        if (state == st_calc) begin
            result <= calc_value;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath, B comes straight from the memory
    //////////////////////////////////////////////////////////////////////

    assign a_ext = a_q;
    assign b_ext = rd_data;

    always_comb begin
        case (op_q)
            op_add:  calc_value = a_ext + b_ext;
            op_sub:  calc_value = a_ext - b_ext;
            op_min:  calc_value = (a_ext < b_ext) ? a_ext : b_ext;
            op_max:  calc_value = (a_ext > b_ext) ? a_ext : b_ext;
            default: calc_value = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/calc_input_top.sv
`default_nettype none

module calc_input_top import calc_num_pkg::*, calc_ctrl_pkg::*; #(
    parameter int TICK_DIVISOR = 1_000_000
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     btn_center,
    input  wire logic     btn_up,
    input  wire logic     btn_down,
    input  wire logic     btn_left,
    input  wire logic     btn_right,
    input  wire logic     go,
    input  wire calc_op_e op,
    output digit_t        ones,
    output digit_t        tens,
    output digit_t        hundreds,
    output logic          sign,
    output cursor_t       cursor,
    output slot_t         slot,
    output logic          busy,
    output result_t       result,
    output logic          result_valid
);

    logic     press_center;
    logic     press_up;
    logic     press_down;
    logic     press_left;
    logic     press_right;

    // writer and reader sides of the shared memory
    logic     wr_req;
    logic     wr_gnt;
    slot_t    wr_slot;
    operand_t wr_data;
    logic     rd_req;
    logic     rd_gnt;
    slot_t    rd_slot;
    operand_t rd_data;

    logic     mem_we;
    logic     mem_re;
    slot_t    mem_addr;
    operand_t mem_wdata;

    button_debouncer #(
        .TICK_DIVISOR (TICK_DIVISOR)
    ) u_button_debouncer (
        .clk          (clk),
        .reset        (reset),
        .btn_center   (btn_center),
        .btn_up       (btn_up),
        .btn_down     (btn_down),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .press_center (press_center),
        .press_up     (press_up),
        .press_down   (press_down),
        .press_left   (press_left),
        .press_right  (press_right)
    );

    operand_entry u_operand_entry (
        .clk          (clk),
        .reset        (reset),
        .press_center (press_center),
        .press_up     (press_up),
        .press_down   (press_down),
        .press_left   (press_left),
        .press_right  (press_right),
        .wr_gnt       (wr_gnt),
        .ones         (ones),
        .tens         (tens),
        .hundreds     (hundreds),
        .sign         (sign),
        .cursor       (cursor),
        .slot         (slot),
        .busy         (busy),
        .wr_req       (wr_req),
        .wr_slot      (wr_slot),
        .wr_data      (wr_data)
    );

    operand_store_arbiter u_operand_store_arbiter (
        .wr_req    (wr_req),
        .wr_slot   (wr_slot),
        .wr_data   (wr_data),
        .rd_req    (rd_req),
        .rd_slot   (rd_slot),
        .wr_gnt    (wr_gnt),
        .rd_gnt    (rd_gnt),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re)
    );

    operand_memory u_operand_memory (
        .clk       (clk),
        .reset     (reset),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .rd_data   (rd_data)
    );

    arith_unit u_arith_unit (
        .clk          (clk),
        .reset        (reset),
        .go           (go),
        .op           (op),
        .rd_gnt       (rd_gnt),
        .rd_data      (rd_data),
        .rd_req       (rd_req),
        .rd_slot      (rd_slot),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- verif/calc_input_properties.sv
`default_nettype none

module calc_input_properties
    import calc_num_pkg::*;
(
    input wire logic   clk,
    input wire logic   reset,
    input wire logic   wr_gnt,
    input wire logic   rd_gnt,
    input wire logic   busy,
    input wire logic   result_valid,
    input wire digit_t ones,
    input wire digit_t tens,
    input wire digit_t hundreds
);

    timeunit 1ns;
    timeprecision 100ps;

    // failures seen so far, watched by the testbench
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // memory arbitration
    //////////////////////////////////////////////////////////////////////

    // one requester on the memory port at a time
    property p_single_grant;
        @(posedge clk) disable iff (reset) !(wr_gnt && rd_gnt);
    endproperty

    a_single_grant: assert property (p_single_grant)
        else begin
            $error("write and read grant are high in the same cycle");
            fail_count++;
        end

    // a write is only granted during a commit
    property p_write_while_busy;
        @(posedge clk) disable iff (reset) wr_gnt |-> busy;
    endproperty

    a_write_while_busy: assert property (p_write_while_busy)
        else begin
            $error("write grant while the entry unit is not busy");
            fail_count++;
        end

    //////////////////////////////////////////////////////////////////////
    // pulses and digit limits
    //////////////////////////////////////////////////////////////////////

    property p_valid_pulse;
        @(posedge clk) disable iff (reset) result_valid |=> !result_valid;
    endproperty

    a_valid_pulse: assert property (p_valid_pulse)
        else begin
            $error("result_valid held high for more than one cycle");
            fail_count++;
        end

    property p_digit_limit;
        @(posedge clk) disable iff (reset)
            (ones <= DIGIT_MAX) && (tens <= DIGIT_MAX) && (hundreds <= DIGIT_MAX);
    endproperty

    a_digit_limit: assert property (p_digit_limit)
        else begin
            $error("a display digit is above nine");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/calc_input_tb.sv
`default_nettype none

module calc_input_tb
    import calc_num_pkg::*, calc_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_DIVISOR   = 4;
    localparam int CLK_PERIOD     = 10;
    // held for three ticks, then released for three
    localparam int HOLD_CYCLES    = 3 * TICK_DIVISOR;
    localparam int PRESS_CYCLES   = 2 * HOLD_CYCLES;
    // far more presses than the sequence below needs
    localparam int PRESS_BUDGET   = 800;
    localparam int WATCHDOG_NS    = PRESS_BUDGET * PRESS_CYCLES * CLK_PERIOD + 8_000;
    localparam int RESULT_TIMEOUT = 40;

    localparam int B_CENTER = 0;
    localparam int B_UP     = 1;
    localparam int B_DOWN   = 2;
    localparam int B_LEFT   = 3;
    localparam int B_RIGHT  = 4;

    logic     clk;
    logic     reset;
    logic     btn_center;
    logic     btn_up;
    logic     btn_down;
    logic     btn_left;
    logic     btn_right;
    logic     go;
    calc_op_e op;
    digit_t   ones;
    digit_t   tens;
    digit_t   hundreds;
    logic     sign;
    cursor_t  cursor;
    slot_t    slot;
    logic     busy;
    result_t  result;
    logic     result_valid;

    // reference model of the entry unit and the memory
    int       m_digit [3];
    logic     m_sign;
    int       m_cursor;
    int       m_slot;
    int       stored [2];
    int       busy_cycles = 0;

    calc_input_top #(
        .TICK_DIVISOR (TICK_DIVISOR)
    ) u_calc_input_top (
        .clk          (clk),
        .reset        (reset),
        .btn_center   (btn_center),
        .btn_up       (btn_up),
        .btn_down     (btn_down),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .go           (go),
        .op           (op),
        .ones         (ones),
        .tens         (tens),
        .hundreds     (hundreds),
        .sign         (sign),
        .cursor       (cursor),
        .slot         (slot),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    bind calc_input_top calc_input_properties u_calc_input_properties (
        .clk          (clk),
        .reset        (reset),
        .wr_gnt       (wr_gnt),
        .rd_gnt       (rd_gnt),
        .busy         (busy),
        .result_valid (result_valid),
        .ones         (ones),
        .tens         (tens),
        .hundreds     (hundreds)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (busy) begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure handling
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        assert (got == exp)
            else report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    // bound assertions stop the run as soon as one fires
    always @(negedge clk) begin
        if (u_calc_input_top.u_calc_input_properties.fail_count != 0) begin
            $display("a bound assertion on calc_input_top failed at %0t ns", $time);
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and model
    //////////////////////////////////////////////////////////////////////

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            B_CENTER: btn_center = level;
            B_UP:     btn_up     = level;
            B_DOWN:   btn_down   = level;
            B_LEFT:   btn_left   = level;
            default:  btn_right  = level;
        endcase
    endtask

    function automatic int model_value();
        int mag;
        mag = m_digit[2] * 100 + m_digit[1] * 10 + m_digit[0];
        return m_sign ? -mag : mag;
    endfunction

    function automatic int expected_result(input calc_op_e o, input int a, input int b);
        case (o)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_min:  return (a < b) ? a : b;
            default: return (a > b) ? a : b;
        endcase
    endfunction

    task automatic apply_model(input int which);
        case (which)
            B_LEFT:  m_cursor = (m_cursor + 1) % 4;
            B_RIGHT: m_cursor = (m_cursor + 3) % 4;
            B_UP: begin
                if (m_cursor == CURSOR_SIGN) begin
                    m_sign = !m_sign;
                end else if (m_digit[m_cursor] < DIGIT_MAX) begin
                    m_digit[m_cursor]++;
                end
            end
            B_DOWN: begin
                if (m_cursor == CURSOR_SIGN) begin
                    m_sign = !m_sign;
                end else if (m_digit[m_cursor] > 0) begin
                    m_digit[m_cursor]--;
                end
            end
            default: begin
                stored[m_slot] = model_value();
                m_slot = 1 - m_slot;
            end
        endcase
    endtask

    task automatic check_display();
        check_int("ones", int'(ones), m_digit[0]);
        check_int("tens", int'(tens), m_digit[1]);
        check_int("hundreds", int'(hundreds), m_digit[2]);
        check_int("sign", int'(sign), int'(m_sign));
        check_int("cursor", int'(cursor), m_cursor);
        check_int("slot", int'(slot), m_slot);
        check_int("busy", int'(busy), 0);
    endtask

    task automatic press(input int which);
        int busy_seen;
        busy_seen = busy_cycles;
        set_button(which, 1'b1);
        step(HOLD_CYCLES);
        set_button(which, 1'b0);
        step(HOLD_CYCLES);
        if (which == B_CENTER) begin
            assert (busy_cycles > busy_seen)
                else begin
                    $display("busy never went high for the commit ending at %0t ns", $time);
                    abort_run();
                end
        end
        apply_model(which);
        check_display();
    endtask

    task automatic move_cursor_to(input int pos);
        while (m_cursor != pos) begin
            if (((pos - m_cursor + 4) % 4) <= 2) begin
                press(B_LEFT);
            end else begin
                press(B_RIGHT);
            end
        end
    endtask

    // set digits and sign, no commit
    task automatic dial_operand(input int mag, input logic neg);
        int target [3];
        target[0] = mag % 10;
        target[1] = (mag / 10) % 10;
        target[2] = mag / 100;
        for (int pos = 0; pos < 3; pos++) begin
            move_cursor_to(pos);
            while (m_digit[pos] < target[pos]) begin
                press(B_UP);
            end
            while (m_digit[pos] > target[pos]) begin
                press(B_DOWN);
            end
        end
        move_cursor_to(CURSOR_SIGN);
        if (m_sign != neg) begin
            press(B_UP);
        end
    endtask

    task automatic enter_operand();
        dial_operand($urandom_range(999), 1'($urandom_range(1)));
        press(B_CENTER);
    endtask

    task automatic wait_result(output int cycles);
        cycles = 0;
        do begin
            step(1);
            go = 1'b0;
            cycles++;
        end while (!result_valid && cycles < RESULT_TIMEOUT);
        if (!result_valid) begin
            $display("result_valid did not arrive within %0d cycles", RESULT_TIMEOUT);
            abort_run();
        end
    endtask

    task automatic run_op(input calc_op_e o);
        int cycles;
        go = 1'b1;
        op = o;
        wait_result(cycles);
        check_int($sformatf("%s latency", o.name()), cycles, 4);
        check_int($sformatf("%s result", o.name()), int'(result),
                  expected_result(o, stored[0], stored[1]));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int a;
        int b;
        int lat;
        void'($urandom(32'hbffc));
        clk        = 1'b0;
        reset      = 1'b1;
        btn_center = 1'b0;
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        go         = 1'b0;
        op         = op_add;
        m_digit    = '{0, 0, 0};
        m_sign     = 1'b0;
        m_cursor   = 0;
        m_slot     = 0;
        stored     = '{0, 0};
        step(4);
        reset = 1'b0;

        // reset values
        check_display();
        check_int("result_valid after reset", int'(result_valid), 0);

        // cursor wraps both ways
        press(B_RIGHT);
        press(B_LEFT);
        repeat (4) press(B_LEFT);

        // saturation at nine and at zero
        repeat (10) press(B_UP);
        repeat (10) press(B_DOWN);
        press(B_UP);

        // glitch of two clk, inside one tick period
        do begin
            step(1);
        end while (!u_calc_input_top.u_button_debouncer.tick);
        step(1);
        btn_up = 1'b1;
        step(2);
        btn_up = 1'b0;
        step(HOLD_CYCLES);
        check_display();

        // sign toggling and a first commit
        move_cursor_to(CURSOR_SIGN);
        press(B_UP);
        press(B_DOWN);
        press(B_UP);
        press(B_CENTER);

        // random operands, all four operations
        repeat (2) begin
            enter_operand();
            enter_operand();
            for (int k = 0; k < 4; k++) begin
                run_op(calc_op_e'(k));
            end
        end

        // go lands in the cycle the commit raises its write request
        dial_operand($urandom_range(999), 1'($urandom_range(1)));
        a = (m_slot == 0) ? model_value() : stored[0];
        b = (m_slot == 1) ? model_value() : stored[1];
        fork
            press(B_CENTER);
            begin
                do begin
                    step(1);
                end while (!u_calc_input_top.press_center);
                go = 1'b1;
                op = op_sub;
                wait_result(lat);
                assert (lat > 4)
                    else report_mismatch($sformatf("contended latency %0d, not above 4", lat));
                check_int("contended op_sub result", int'(result),
                          expected_result(op_sub, a, b));
            end
        join
        step(2);

        if (u_calc_input_top.u_calc_input_properties.fail_count != 0) begin
            $display("bound assertion failures at the end of the run");
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- calc_input.f
logic/calc_num_pkg.sv
logic/calc_ctrl_pkg.sv
logic/button_debouncer.sv
logic/operand_entry.sv
logic/operand_store_arbiter.sv
logic/operand_memory.sv
logic/arith_unit.sv
logic/calc_input_top.sv
verif/calc_input_properties.sv
verif/calc_input_tb.sv
